// ==== rs.f ====
rs_pkg.sv
rs_occupancy_counter.sv
rs_alloc_select.sv
rs_entry_array.sv
rs_issue_select.sv
rs_top.sv
tb_rs_top.sv

// ==== rs_alloc_select.sv ====
module rs_alloc_select #(
    parameter int  RS_ENTRY_NUM = 8,
    parameter int  DP_NUM       = 2,
    localparam int DP_CNT_W     = $clog2(DP_NUM + 1),
    localparam int DP_IDX_W     = (DP_NUM > 1) ? $clog2(DP_NUM) : 1
) (
    input  logic [RS_ENTRY_NUM-1:0]                entry_valid_i,
    input  logic [RS_ENTRY_NUM-1:0]                issue_sel_i,
    input  logic [DP_CNT_W-1:0]                    dp_num_i,
    output logic [RS_ENTRY_NUM-1:0]                dp_sel_o,
    output logic [RS_ENTRY_NUM-1:0][DP_IDX_W-1:0]  dp_chan_o
);

    // Empty entries, plus the ones leaving this cycle
    logic [RS_ENTRY_NUM-1:0]              free_vec;
    // Input of each encoder level
    logic [DP_NUM-1:0][RS_ENTRY_NUM-1:0]  pe_in;
    // One-hot pick of each level, zero when nothing is free
    logic [DP_NUM-1:0][RS_ENTRY_NUM-1:0]  pe_pick;

    assign free_vec = ~entry_valid_i | issue_sel_i;

    // ----------------------------------------------------------------------
    // Cascaded priority encoders, lowest index first
    // ----------------------------------------------------------------------
    for (genvar g = 0; g < DP_NUM; g++) begin : g_pe
        if (g == 0) begin : g_first
            assign pe_in[g] = free_vec;
        end else begin : g_next
            // Remove the entry taken by the level above
            assign pe_in[g] = pe_in[g-1] & ~pe_pick[g-1];
        end

        // Isolate the lowest set bit
        assign pe_pick[g] = pe_in[g] & (~pe_in[g] + RS_ENTRY_NUM'(1));
    end

    // ----------------------------------------------------------------------
    // Per-entry select and channel route
    // ----------------------------------------------------------------------
    always_comb begin
        dp_sel_o  = '0;
        dp_chan_o = '0;
        for (int e = 0; e < RS_ENTRY_NUM; e++) begin
            for (int c = 0; c < DP_NUM; c++) begin
                // Channel counts only below dp_num_i
                if (pe_pick[c][e] && (DP_CNT_W'(c) < dp_num_i)) begin
                    dp_sel_o[e]  = 1'b1;
                    dp_chan_o[e] = DP_IDX_W'(c);
                end
            end
        end
    end

endmodule

// ==== rs_entry_array.sv ====
module rs_entry_array
    import rs_pkg::*;
#(
    parameter int  RS_ENTRY_NUM = 8,
    parameter int  DP_NUM       = 2,
    parameter int  CDB_NUM      = 2,
    localparam int DP_IDX_W     = (DP_NUM > 1) ? $clog2(DP_NUM) : 1
) (
    input  logic                                   clk_i,
    input  logic                                   rst_i,
    input  logic                                   flush_i,
    input  dp_inst_t [DP_NUM-1:0]                  dp_inst_i,
    input  logic [RS_ENTRY_NUM-1:0]                dp_sel_i,
    input  logic [RS_ENTRY_NUM-1:0][DP_IDX_W-1:0]  dp_chan_i,
    input  logic [RS_ENTRY_NUM-1:0]                issue_sel_i,
    input  cdb_t [CDB_NUM-1:0]                     cdb_i,
    output rs_entry_t [RS_ENTRY_NUM-1:0]           entries_o
);

    // Occupied flags
    logic [RS_ENTRY_NUM-1:0]            valid_q;
    // Stored instructions
    dp_inst_t [RS_ENTRY_NUM-1:0]        inst_q;
    // Tag match on any completion bus
    logic [RS_ENTRY_NUM-1:0]            wake1;
    logic [RS_ENTRY_NUM-1:0]            wake2;

    // ----------------------------------------------------------------------
    // CDB comparator network
    // ----------------------------------------------------------------------
    always_comb begin
        wake1 = '0;
        wake2 = '0;
        for (int e = 0; e < RS_ENTRY_NUM; e++) begin
            for (int b = 0; b < CDB_NUM; b++) begin
                if (cdb_i[b].valid) begin
                    // Both sources compared on their own
                    if (cdb_i[b].tag == inst_q[e].tag1) begin
                        wake1[e] = 1'b1;
                    end
                    if (cdb_i[b].tag == inst_q[e].tag2) begin
                        wake2[e] = 1'b1;
                    end
                end
            end
        end
    end

    // ----------------------------------------------------------------------
    // Entry state
    // ----------------------------------------------------------------------
    // Flush beats dispatch, dispatch beats issue release
    always_ff @(posedge clk_i) begin
        for (int e = 0; e < RS_ENTRY_NUM; e++) begin
            if (rst_i || flush_i) begin
                valid_q[e] <= 1'b0;
            end else if (dp_sel_i[e]) begin
                valid_q[e] <= 1'b1;
            end else if (issue_sel_i[e]) begin
                valid_q[e] <= 1'b0;
            end
        end
    end

    // Payload only means something while valid_q is set
    always_ff @(posedge clk_i) begin
        for (int e = 0; e < RS_ENTRY_NUM; e++) begin
            if (dp_sel_i[e]) begin
                // Route the chosen channel, CDB of this cycle is missed
                inst_q[e] <= dp_inst_i[dp_chan_i[e]];
            end else if (valid_q[e] && !issue_sel_i[e]) begin
                // Wakeup of a waiting entry
                if (wake1[e]) begin
                    inst_q[e].tag1_ready <= 1'b1;
                end
                if (wake2[e]) begin
                    inst_q[e].tag2_ready <= 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int e = 0; e < RS_ENTRY_NUM; e++) begin
            entries_o[e].valid = valid_q[e];
            entries_o[e].inst  = inst_q[e];
        end
    end

    // Allocation never lands on an occupied entry that stays
    assert property (@(posedge clk_i) disable iff (rst_i)
        (dp_sel_i & valid_q & ~issue_sel_i) == '0)
        else $error("dispatch selected an occupied entry");

endmodule

// ==== rs_issue_select.sv ====
module rs_issue_select
    import rs_pkg::*;
#(
    parameter int RS_ENTRY_NUM = 8,
    parameter int IS_NUM       = 2
) (
    input  rs_entry_t [RS_ENTRY_NUM-1:0]  entries_i,
    input  fu_mask_t                      fu_ready_i,
    output logic [RS_ENTRY_NUM-1:0]       issue_sel_o,
    output is_inst_t [IS_NUM-1:0]         is_inst_o
);

    // Entries able to leave this cycle
    logic [RS_ENTRY_NUM-1:0]              ready_vec;
    // Input of each encoder level
    logic [IS_NUM-1:0][RS_ENTRY_NUM-1:0]  pe_in;
    // One-hot pick of each level
    logic [IS_NUM-1:0][RS_ENTRY_NUM-1:0]  pe_pick;

    // ----------------------------------------------------------------------
    // Ready check
    // ----------------------------------------------------------------------
    always_comb begin
        for (int e = 0; e < RS_ENTRY_NUM; e++) begin
            // Both sources ready and the unit class free
            ready_vec[e] = entries_i[e].valid
                        && entries_i[e].inst.tag1_ready
                        && entries_i[e].inst.tag2_ready
                        && ((entries_i[e].inst.fu & fu_ready_i) != '0);
        end
    end

    // ----------------------------------------------------------------------
    // Cascaded priority encoders, channel 0 takes the lowest index
    // ----------------------------------------------------------------------
    for (genvar g = 0; g < IS_NUM; g++) begin : g_pe
        if (g == 0) begin : g_first
            assign pe_in[g] = ready_vec;
        end else begin : g_next
            assign pe_in[g] = pe_in[g-1] & ~pe_pick[g-1];
        end

        // Lowest set bit
        assign pe_pick[g] = pe_in[g] & (~pe_in[g] + RS_ENTRY_NUM'(1));
    end

    // ----------------------------------------------------------------------
    // Issue switch
    // ----------------------------------------------------------------------
    always_comb begin
        issue_sel_o = '0;
        is_inst_o   = '0;
        for (int c = 0; c < IS_NUM; c++) begin
            for (int e = 0; e < RS_ENTRY_NUM; e++) begin
                if (pe_pick[c][e]) begin
                    issue_sel_o[e]        = 1'b1;
                    is_inst_o[c].valid    = 1'b1;
                    is_inst_o[c].pc       = entries_i[e].inst.pc;
                    // Sequential next pc
                    is_inst_o[c].npc      = entries_i[e].inst.pc + PC_W'(4);
                    is_inst_o[c].tag1     = entries_i[e].inst.tag1;
                    is_inst_o[c].tag2     = entries_i[e].inst.tag2;
                    is_inst_o[c].dest_tag = entries_i[e].inst.dest_tag;
                    is_inst_o[c].rob_idx  = entries_i[e].inst.rob_idx;
                    is_inst_o[c].fu       = entries_i[e].inst.fu;
                end
            end
        end
    end

    // Each entry goes out on one channel at most
    always_comb begin
        for (int a = 0; a < IS_NUM; a++) begin
            for (int b = a + 1; b < IS_NUM; b++) begin
                assert final ((pe_pick[a] & pe_pick[b]) == '0)
                    else $error("two issue channels picked the same entry");
            end
        end
    end

endmodule

// ==== rs_occupancy_counter.sv ====
module rs_occupancy_counter
    import rs_pkg::*;
#(
    parameter int  RS_ENTRY_NUM = 8,
    parameter int  DP_NUM       = 2,
    parameter int  IS_NUM       = 2,
    localparam int DP_CNT_W     = $clog2(DP_NUM + 1)
) (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      flush_i,
    input  logic [DP_CNT_W-1:0]       dp_num_i,
    input  is_inst_t [IS_NUM-1:0]     is_inst_i,
    output logic [DP_CNT_W-1:0]       avail_num_o
);

    localparam int CNT_W    = $clog2(RS_ENTRY_NUM + 1);
    localparam int IS_CNT_W = $clog2(IS_NUM + 1);

    // Entries holding an instruction
    logic [CNT_W-1:0]    occ_cnt;
    // Entries leaving this cycle
    logic [IS_CNT_W-1:0] is_cnt;
    // Free entries for the next cycle, unsaturated
    logic [CNT_W-1:0]    free_cnt;

    // Count valid issue channels
    always_comb begin
        is_cnt = '0;
        for (int c = 0; c < IS_NUM; c++) begin
            if (is_inst_i[c].valid) begin
                is_cnt = is_cnt + IS_CNT_W'(1);
            end
        end
    end

    // Flush drops dispatches of the same cycle as well
    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            occ_cnt <= '0;
        end else begin
            occ_cnt <= occ_cnt + CNT_W'(dp_num_i) - CNT_W'(is_cnt);
        end
    end

    // Issued entries are reusable at this edge, so they count as free
    always_comb begin
        free_cnt = CNT_W'(RS_ENTRY_NUM) - occ_cnt + CNT_W'(is_cnt);
        if (free_cnt >= CNT_W'(DP_NUM)) begin
            avail_num_o = DP_CNT_W'(DP_NUM);
        end else begin
            avail_num_o = DP_CNT_W'(free_cnt);
        end
    end

    // Occupancy stays within the array
    assert property (@(posedge clk_i) disable iff (rst_i) occ_cnt <= CNT_W'(RS_ENTRY_NUM))
        else $error("occupancy count above entry number");

    // Core keeps dispatch within the advertised free count
    assert property (@(posedge clk_i) disable iff (rst_i) dp_num_i <= avail_num_o)
        else $error("dispatch count above available count");

endmodule

// ==== rs_pkg.sv ====
package rs_pkg;

    // ----------------------------------------------------------------------
    // Field widths
    // ----------------------------------------------------------------------
    // Physical register tag
    parameter int TAG_W = 6;
    // Program counter
    parameter int PC_W  = 32;
    // Reorder buffer index
    parameter int ROB_W = 5;
    // One bit per functional unit class
    parameter int FU_W  = 5;

    // Bit positions inside fu_mask_t, same layout for FU ready levels
    parameter int FU_LOAD  = 0;
    parameter int FU_STORE = 1;
    parameter int FU_BR    = 2;
    parameter int FU_MULT  = 3;
    parameter int FU_ALU   = 4;

    typedef logic [TAG_W-1:0] tag_t;
    typedef logic [PC_W-1:0]  pc_t;
    typedef logic [ROB_W-1:0] rob_idx_t;
    typedef logic [FU_W-1:0]  fu_mask_t;

    // ----------------------------------------------------------------------
    // Bundles
    // ----------------------------------------------------------------------
    // One dispatched instruction, fu is one-hot
    typedef struct packed {
        pc_t      pc;
        tag_t     tag1;
        logic     tag1_ready;
        tag_t     tag2;
        logic     tag2_ready;
        tag_t     dest_tag;
        rob_idx_t rob_idx;
        fu_mask_t fu;
    } dp_inst_t;

    // One station entry
    typedef struct packed {
        logic     valid;
        dp_inst_t inst;
    } rs_entry_t;

    // One completion bus
    typedef struct packed {
        logic valid;
        tag_t tag;
    } cdb_t;

    // One issue channel, tags go to the register file read
    typedef struct packed {
        logic     valid;
        pc_t      pc;
        pc_t      npc;
        tag_t     tag1;
        tag_t     tag2;
        tag_t     dest_tag;
        rob_idx_t rob_idx;
        fu_mask_t fu;
    } is_inst_t;

endpackage

// ==== rs_top.sv ====
module rs_top
    import rs_pkg::*;
#(
    parameter int  RS_ENTRY_NUM = 8,
    parameter int  DP_NUM       = 2,
    parameter int  IS_NUM       = 2,
    parameter int  CDB_NUM      = 2,
    localparam int DP_CNT_W     = $clog2(DP_NUM + 1)
) (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   flush_i,
    input  logic [DP_CNT_W-1:0]    dp_num_i,
    input  dp_inst_t [DP_NUM-1:0]  dp_inst_i,
    input  cdb_t [CDB_NUM-1:0]     cdb_i,
    input  fu_mask_t               fu_ready_i,
    output is_inst_t [IS_NUM-1:0]  is_inst_o,
    output logic [DP_CNT_W-1:0]    avail_num_o
);

    localparam int DP_IDX_W = (DP_NUM > 1) ? $clog2(DP_NUM) : 1;

    // Registered entry state
    rs_entry_t [RS_ENTRY_NUM-1:0]         entries;
    logic [RS_ENTRY_NUM-1:0]              entry_valid;
    // Entries leaving at this edge
    logic [RS_ENTRY_NUM-1:0]              issue_sel;
    // Entries written at this edge and their source channel
    logic [RS_ENTRY_NUM-1:0]              dp_sel;
    logic [RS_ENTRY_NUM-1:0][DP_IDX_W-1:0] dp_chan;

    always_comb begin
        for (int e = 0; e < RS_ENTRY_NUM; e++) begin
            entry_valid[e] = entries[e].valid;
        end
    end

    // ----------------------------------------------------------------------
    // Occupancy and free count
    // ----------------------------------------------------------------------
    rs_occupancy_counter #(
        .RS_ENTRY_NUM (RS_ENTRY_NUM),
        .DP_NUM       (DP_NUM),
        .IS_NUM       (IS_NUM)
    ) u_occupancy (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .flush_i      (flush_i),
        .dp_num_i     (dp_num_i),
        .is_inst_i    (is_inst_o),
        .avail_num_o  (avail_num_o)
    );

    // Free entry choice for dispatch
    rs_alloc_select #(
        .RS_ENTRY_NUM (RS_ENTRY_NUM),
        .DP_NUM       (DP_NUM)
    ) u_alloc (
        .entry_valid_i (entry_valid),
        .issue_sel_i   (issue_sel),
        .dp_num_i      (dp_num_i),
        .dp_sel_o      (dp_sel),
        .dp_chan_o     (dp_chan)
    );

    // ----------------------------------------------------------------------
    // Storage and wakeup
    // ----------------------------------------------------------------------
    rs_entry_array #(
        .RS_ENTRY_NUM (RS_ENTRY_NUM),
        .DP_NUM       (DP_NUM),
        .CDB_NUM      (CDB_NUM)
    ) u_entries (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .flush_i      (flush_i),
        .dp_inst_i    (dp_inst_i),
        .dp_sel_i     (dp_sel),
        .dp_chan_i    (dp_chan),
        .issue_sel_i  (issue_sel),
        .cdb_i        (cdb_i),
        .entries_o    (entries)
    );

    // Combinational issue from registered state
    rs_issue_select #(
        .RS_ENTRY_NUM (RS_ENTRY_NUM),
        .IS_NUM       (IS_NUM)
    ) u_issue (
        .entries_i    (entries),
        .fu_ready_i   (fu_ready_i),
        .issue_sel_o  (issue_sel),
        .is_inst_o    (is_inst_o)
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the reservation station testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 --top-module tb_rs_top -f rs.f; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_rs_top 2>&1)
status=$?
echo "$out"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "PASS: all tests"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// ==== tb_rs_top.sv ====
module tb_rs_top
    import rs_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    // Same values as the rs_top defaults
    localparam int RS_ENTRY_NUM   = 8;
    localparam int DP_NUM         = 2;
    localparam int IS_NUM         = 2;
    localparam int CDB_NUM        = 2;
    localparam int DP_CNT_W       = $clog2(DP_NUM + 1);
    // Tests run about 200 cycles at most
    localparam int TIMEOUT_CYCLES = 1000;

    logic                  clk_i = 1'b0;
    logic                  rst_i;
    logic                  flush_i;
    logic [DP_CNT_W-1:0]   dp_num_i;
    dp_inst_t [DP_NUM-1:0] dp_inst_i;
    cdb_t [CDB_NUM-1:0]    cdb_i;
    fu_mask_t              fu_ready_i;
    is_inst_t [IS_NUM-1:0] is_inst_o;
    logic [DP_CNT_W-1:0]   avail_num_o;

    int unsigned cycle_cnt = 0;
    logic [31:0] rng_state = 32'd75;
    string       test_name = "setup";

    rs_top #(
        .RS_ENTRY_NUM (RS_ENTRY_NUM),
        .DP_NUM       (DP_NUM),
        .IS_NUM       (IS_NUM),
        .CDB_NUM      (CDB_NUM)
    ) dut0 (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .flush_i      (flush_i),
        .dp_num_i     (dp_num_i),
        .dp_inst_i    (dp_inst_i),
        .cdb_i        (cdb_i),
        .fu_ready_i   (fu_ready_i),
        .is_inst_o    (is_inst_o),
        .avail_num_o  (avail_num_o)
    );

    // 40 ns period
    always #20 clk_i = ~clk_i;

    // Run limit
    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: tests still running after %0d cycles", cycle_cnt);
            $display("FAIL: see errors above");
            $fatal(1);
        end
    end

    // ----------------------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------------------
    // Xorshift32 stream
    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("FAIL %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
            $display("FAIL: see errors above");
            $fatal(1);
        end
    endtask

    // Inputs change 2 ns after the edge
    task automatic next_cycle();
        @(posedge clk_i);
        #2;
    endtask

    // Let combinational outputs settle before sampling
    task automatic settle();
        #1;
    endtask

    task automatic drive_idle();
        flush_i   = 1'b0;
        dp_num_i  = '0;
        dp_inst_i = '0;
        cdb_i     = '0;
    endtask

    // Random fields, tag2 always ready, one-hot fu
    function automatic dp_inst_t random_inst(input logic t1_ready, input int fu_bit);
        dp_inst_t inst;
        inst.pc          = pc_t'(next_rand());
        inst.tag1        = tag_t'(next_rand());
        inst.tag1_ready  = t1_ready;
        inst.tag2        = tag_t'(next_rand());
        inst.tag2_ready  = 1'b1;
        inst.dest_tag    = tag_t'(next_rand());
        inst.rob_idx     = rob_idx_t'(next_rand());
        inst.fu          = '0;
        inst.fu[fu_bit]  = 1'b1;
        return inst;
    endfunction

    // Free entries next cycle, saturated at the dispatch width
    function automatic int expected_avail(input int occupied, input int issued);
        int free_cnt;
        free_cnt = RS_ENTRY_NUM - occupied + issued;
        if (free_cnt > DP_NUM) begin
            return DP_NUM;
        end
        return free_cnt;
    endfunction

    task automatic check_avail(input int occupied, input int issued);
        check_value("avail_num", 64'(expected_avail(occupied, issued)), 64'(avail_num_o));
    endtask

    // Channel c carries exp, npc is the sequential pc
    task automatic check_issue(input int c, input dp_inst_t exp);
        pc_t npc_exp;
        npc_exp = exp.pc + PC_W'(4);
        check_value($sformatf("ch%0d valid", c), 64'(1), 64'(is_inst_o[c].valid));
        check_value($sformatf("ch%0d pc", c), 64'(exp.pc), 64'(is_inst_o[c].pc));
        check_value($sformatf("ch%0d npc", c), 64'(npc_exp), 64'(is_inst_o[c].npc));
        check_value($sformatf("ch%0d tag1", c), 64'(exp.tag1), 64'(is_inst_o[c].tag1));
        check_value($sformatf("ch%0d tag2", c), 64'(exp.tag2), 64'(is_inst_o[c].tag2));
        check_value($sformatf("ch%0d dest", c), 64'(exp.dest_tag), 64'(is_inst_o[c].dest_tag));
        check_value($sformatf("ch%0d rob", c), 64'(exp.rob_idx), 64'(is_inst_o[c].rob_idx));
        check_value($sformatf("ch%0d fu", c), 64'(exp.fu), 64'(is_inst_o[c].fu));
    endtask

    task automatic check_idle(input string what);
        for (int c = 0; c < IS_NUM; c++) begin
            check_value($sformatf("%s ch%0d valid", what, c), 64'(0), 64'(is_inst_o[c].valid));
        end
    endtask

    // ----------------------------------------------------------------------
    // Tests
    // ----------------------------------------------------------------------
    task automatic test_reset();
        test_name = "test_reset";
        settle();
        check_avail(0, 0);
        check_idle("after reset");
    endtask

    task automatic test_ready_issue();
        dp_inst_t inst;
        test_name = "test_ready_issue";
        inst = random_inst(1'b1, FU_ALU);
        next_cycle();
        dp_num_i     = DP_CNT_W'(1);
        dp_inst_i[0] = inst;
        settle();
        check_idle("dispatch cycle");
        next_cycle();
        drive_idle();
        settle();
        // Out one cycle after dispatch
        check_issue(0, inst);
        check_value("ch1 valid", 64'(0), 64'(is_inst_o[1].valid));
        check_avail(1, 1);
        next_cycle();
        settle();
        check_idle("after issue");
    endtask

    task automatic test_wakeup();
        dp_inst_t inst;
        tag_t     wrong_tag;
        test_name = "test_wakeup";
        inst      = random_inst(1'b0, FU_LOAD);
        wrong_tag = inst.tag1 ^ tag_t'(1);
        next_cycle();
        dp_num_i     = DP_CNT_W'(1);
        dp_inst_i[0] = inst;
        next_cycle();
        drive_idle();
        // Source 1 still pending
        repeat (3) begin
            settle();
            check_idle("waiting");
            next_cycle();
        end
        cdb_i[1].valid = 1'b1;
        cdb_i[1].tag   = wrong_tag;
        settle();
        check_idle("wrong tag cycle");
        next_cycle();
        cdb_i = '0;
        settle();
        check_idle("after wrong tag");
        next_cycle();
        cdb_i[0].valid = 1'b1;
        cdb_i[0].tag   = inst.tag1;
        settle();
        check_idle("right tag cycle");
        next_cycle();
        cdb_i = '0;
        settle();
        check_issue(0, inst);
        next_cycle();
        settle();
        check_idle("after issue");
    endtask

    task automatic test_fu_backpressure();
        dp_inst_t first;
        dp_inst_t second;
        test_name = "test_fu_backpressure";
        first     = random_inst(1'b1, FU_ALU);
        second    = random_inst(1'b1, FU_ALU);
        next_cycle();
        fu_ready_i         = '1;
        fu_ready_i[FU_ALU] = 1'b0;
        dp_num_i           = DP_CNT_W'(2);
        dp_inst_i[0]       = first;
        dp_inst_i[1]       = second;
        next_cycle();
        drive_idle();
        // Both held while the ALU is busy
        repeat (4) begin
            settle();
            check_idle("ALU busy");
            check_avail(2, 0);
            next_cycle();
        end
        fu_ready_i[FU_ALU] = 1'b1;
        settle();
        // Entry 0 goes first, so channel order shows entry order
        check_issue(0, first);
        check_issue(1, second);
        check_avail(2, 2);
        next_cycle();
        settle();
        check_idle("after issue");
    endtask

    task automatic test_fill_flush();
        dp_inst_t inst;
        tag_t     waiting_tags[$];
        int       occupied;
        test_name = "test_fill_flush";
        occupied  = 0;
        // Four pairs fill all eight entries
        for (int k = 0; k < 4; k++) begin
            next_cycle();
            dp_num_i = DP_CNT_W'(DP_NUM);
            for (int c = 0; c < DP_NUM; c++) begin
                inst         = random_inst(1'b0, FU_MULT);
                dp_inst_i[c] = inst;
                waiting_tags.push_back(inst.tag1);
            end
            settle();
            check_avail(occupied, 0);
            check_idle("filling");
            occupied = occupied + DP_NUM;
        end
        next_cycle();
        drive_idle();
        settle();
        check_avail(occupied, 0);
        check_idle("full");
        next_cycle();
        flush_i = 1'b1;
        next_cycle();
        flush_i  = 1'b0;
        occupied = 0;
        settle();
        check_avail(occupied, 0);
        check_idle("after flush");
        // Old tags must wake nothing
        for (int k = 0; k < 4; k++) begin
            next_cycle();
            for (int b = 0; b < CDB_NUM; b++) begin
                cdb_i[b].valid = 1'b1;
                cdb_i[b].tag   = waiting_tags[k * CDB_NUM + b];
            end
            settle();
            check_idle("old tag broadcast");
        end
        next_cycle();
        cdb_i = '0;
        settle();
        check_idle("after broadcast");
    endtask

    initial begin
        rst_i      = 1'b1;
        fu_ready_i = '1;
        drive_idle();
        repeat (5) @(posedge clk_i);
        #2;
        rst_i = 1'b0;
        test_reset();
        test_ready_issue();
        test_wakeup();
        test_fu_backpressure();
        test_fill_flush();
        $display("PASS: all tests");
        $finish;
    end

endmodule
